// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;      // data, address or instruction word
    typedef logic [4:0]  reg_idx_t;   // x0..x31
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes of the supported subset
    localparam opcode_t op_reg   = 7'b0110011;   // add sub and or xor slt
    localparam opcode_t op_imm   = 7'b0010011;   // addi andi ori xori slti
    localparam opcode_t op_lui   = 7'b0110111;
    localparam opcode_t op_load  = 7'b0000011;
    localparam opcode_t op_store = 7'b0100011;

    localparam funct3_t f3_add  = 3'b000;   // add, sub, addi
    localparam funct3_t f3_slt  = 3'b010;   // signed compare
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;
    localparam funct3_t f3_word = 3'b010;   // lw / sw width

    localparam funct7_t funct7_sub = 7'b0100000;   // add -> sub

    function automatic opcode_t inst_opcode(input word_t inst);
        return inst[6:0];
    endfunction

    function automatic reg_idx_t inst_rd(input word_t inst);
        return inst[11:7];
    endfunction

    function automatic reg_idx_t inst_rs1(input word_t inst);
        return inst[19:15];
    endfunction

    function automatic reg_idx_t inst_rs2(input word_t inst);
        return inst[24:20];
    endfunction

    function automatic funct3_t inst_funct3(input word_t inst);
        return inst[14:12];
    endfunction

    function automatic funct7_t inst_funct7(input word_t inst);
        return inst[31:25];
    endfunction

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,      // signed
        alu_pass_b    // lui, result is operand b
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_e;

    // one decoded item as it leaves decode
    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::word_t    inst;
        isa_pkg::word_t    a;            // rs1 value
        isa_pkg::word_t    b;            // rs2 value or immediate
        isa_pkg::word_t    store_data;   // rs2 value for sw
        isa_pkg::reg_idx_t rd;
        logic              wen;
        alu_op_e           alu_op;
        mem_op_e           mem_op;
    } ctrl_word_t;

endpackage

`default_nettype wire

// File: source/fetch_stage.sv
`default_nettype none
`timescale 1ns/100ps

module fetch_stage #(
    parameter isa_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire isa_pkg::word_t inst,
    input  wire                 inst_ready,
    input  wire                 out_ready,    // decode can take the item
    output isa_pkg::word_t      pc,
    output logic                pc_valid,
    output logic                out_valid,
    output isa_pkg::word_t      out_pc,
    output isa_pkg::word_t      out_inst
);
    import isa_pkg::*;

    logic  started;    // low for the first cycle out of reset
    logic  fire;       // instruction taken on this edge
    word_t pc_next;

    assign pc_valid = started && (!out_valid || out_ready);   // room in output reg
    assign fire     = pc_valid && inst_ready;
    assign pc_next  = pc + 32'd4;   // straight-line only, no branches

    always_ff @(posedge clk) begin
        if (reset) begin
            started   <= 1'b0;
            pc        <= reset_pc;
            out_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (fire) begin
                pc        <= pc_next;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;   // drained, nothing behind it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_pc   <= pc;
            out_inst <= inst;
        end
    end

    // the instruction port relies on pc staying put and offered until taken
    a_pc_hold: assert property (@(posedge clk) disable iff (reset)
        pc_valid && !inst_ready |=> pc_valid && $stable(pc))
        else $error("pc changed or was withdrawn while the fetch was not taken");

endmodule

`default_nettype wire

// File: decode/regfile.sv
`default_nettype none
`timescale 1ns/100ps

module regfile (
    input  wire                    clk,
    input  wire                    reset,
    input  wire isa_pkg::reg_idx_t rs1_idx,
    input  wire isa_pkg::reg_idx_t rs2_idx,
    input  wire                    wb_en,
    input  wire isa_pkg::reg_idx_t wb_rd,
    input  wire isa_pkg::word_t    wb_data,
    output isa_pkg::word_t         rs1_data,
    output isa_pkg::word_t         rs2_data
);
    import isa_pkg::*;

    word_t regs [32];   // entry 0 is never written

    // same-cycle write wins, so the writeback item never stalls decode
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;   // architectural state starts at zero
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;   // writes to x0 dropped
        end
    end

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`default_nettype none
`timescale 1ns/100ps

module decode_stage (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    in_valid,
    input  wire isa_pkg::word_t    in_pc,
    input  wire isa_pkg::word_t    in_inst,
    input  wire isa_pkg::word_t    rs1_data,
    input  wire isa_pkg::word_t    rs2_data,
    input  wire isa_pkg::reg_idx_t ex_busy_rd,
    input  wire                    ex_busy_wen,
    input  wire isa_pkg::reg_idx_t mem_busy_rd,
    input  wire                    mem_busy_wen,
    input  wire                    out_ready,
    output logic                   in_ready,
    output isa_pkg::reg_idx_t      rs1_idx,
    output isa_pkg::reg_idx_t      rs2_idx,
    output logic                   out_valid,
    output isa_pkg::word_t         out_pc,
    output isa_pkg::word_t         out_inst,
    output isa_pkg::word_t         out_a,
    output isa_pkg::word_t         out_b,
    output isa_pkg::word_t         out_store_data,
    output isa_pkg::reg_idx_t      out_rd,
    output logic                   out_wen,
    output pipe_pkg::alu_op_e      out_alu_op,
    output pipe_pkg::mem_op_e      out_mem_op
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    logic       use_rs1;    // source actually read by this opcode
    logic       use_rs2;
    logic       hazard;
    logic       accept;
    ctrl_word_t dec;        // decoded from the incoming item
    ctrl_word_t q;          // output register

    function automatic alu_op_e alu_from_f3(input funct3_t f3, input logic sub);
        alu_op_e op;
        case (f3)
            f3_add:  op = sub ? alu_sub : alu_add;
            f3_slt:  op = alu_slt;
            f3_xor:  op = alu_xor;
            f3_or:   op = alu_or;
            f3_and:  op = alu_and;
            default: op = alu_add;
        endcase
        return op;
    endfunction

    // x0 never counts as a pending write
    function automatic logic busy(input reg_idx_t idx, input reg_idx_t rd, input logic wen);
        return wen && (rd == idx) && (idx != '0);
    endfunction

    function automatic logic pending(input reg_idx_t idx);
        return busy(idx, q.rd, out_valid && q.wen)    // still in our output reg
            || busy(idx, ex_busy_rd, ex_busy_wen)
            || busy(idx, mem_busy_rd, mem_busy_wen);
    endfunction

    function automatic logic supported(input word_t inst);
        opcode_t op;
        op = inst_opcode(inst);
        return (op inside {op_reg, op_imm, op_lui})
            || ((op inside {op_load, op_store}) && inst_funct3(inst) == f3_word);
    endfunction

    assign rs1_idx = inst_rs1(in_inst);
    assign rs2_idx = inst_rs2(in_inst);
    assign imm_i   = {{20{in_inst[31]}}, in_inst[31:20]};
    assign imm_s   = {{20{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
    assign imm_u   = {in_inst[31:12], 12'h000};

    always_comb begin
        use_rs1        = 1'b1;
        use_rs2        = 1'b0;
        dec.pc         = in_pc;
        dec.inst       = in_inst;
        dec.a          = rs1_data;
        dec.b          = imm_i;         // i-type default, also lw
        dec.store_data = rs2_data;
        dec.rd         = inst_rd(in_inst);
        dec.wen        = 1'b1;
        dec.alu_op     = alu_add;
        dec.mem_op     = mem_none;
        case (inst_opcode(in_inst))
            op_reg: begin
                use_rs2    = 1'b1;
                dec.b      = rs2_data;
                dec.alu_op = alu_from_f3(inst_funct3(in_inst),
                                         inst_funct7(in_inst) == funct7_sub);
            end
            op_imm: dec.alu_op = alu_from_f3(inst_funct3(in_inst), 1'b0);
            op_lui: begin
                use_rs1    = 1'b0;
                dec.b      = imm_u;
                dec.alu_op = alu_pass_b;
            end
            op_load: dec.mem_op = mem_load;   // address = rs1 + imm_i
            op_store: begin
                use_rs2    = 1'b1;
                dec.b      = imm_s;
                dec.wen    = 1'b0;
                dec.mem_op = mem_store;
            end
            default: begin                    // not in the subset, no effect
                use_rs1 = 1'b0;
                dec.wen = 1'b0;
            end
        endcase
    end

    always_comb begin
        hazard = (use_rs1 && pending(rs1_idx)) || (use_rs2 && pending(rs2_idx));
    end

    assign in_ready = !hazard && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            q <= dec;
        end
    end

    assign out_pc         = q.pc;
    assign out_inst       = q.inst;
    assign out_a          = q.a;
    assign out_b          = q.b;
    assign out_store_data = q.store_data;
    assign out_rd         = q.rd;
    assign out_wen        = q.wen;
    assign out_alu_op     = q.alu_op;
    assign out_mem_op     = q.mem_op;

    a_supported_only: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> supported(q.inst))
        else $error("unsupported instruction left decode");

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`default_nettype none
`timescale 1ns/100ps

module execute_stage (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    in_valid,
    input  wire isa_pkg::word_t    in_pc,
    input  wire isa_pkg::word_t    in_inst,
    input  wire isa_pkg::word_t    in_a,
    input  wire isa_pkg::word_t    in_b,
    input  wire isa_pkg::word_t    in_store_data,
    input  wire isa_pkg::reg_idx_t in_rd,
    input  wire                    in_wen,
    input  wire pipe_pkg::alu_op_e in_alu_op,
    input  wire pipe_pkg::mem_op_e in_mem_op,
    input  wire                    out_ready,
    output logic                   in_ready,
    output logic                   out_valid,
    output isa_pkg::word_t         out_pc,
    output isa_pkg::word_t         out_inst,
    output isa_pkg::word_t         out_result,      // alu value or address
    output isa_pkg::word_t         out_store_data,
    output isa_pkg::reg_idx_t      out_rd,
    output logic                   out_wen,
    output pipe_pkg::mem_op_e      out_mem_op,
    output isa_pkg::reg_idx_t      ex_busy_rd,
    output logic                   ex_busy_wen
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t alu_result;
    logic  accept;

    always_comb begin
        case (in_alu_op)
            alu_add:    alu_result = in_a + in_b;   // also lw / sw address
            alu_sub:    alu_result = in_a - in_b;
            alu_and:    alu_result = in_a & in_b;
            alu_or:     alu_result = in_a | in_b;
            alu_xor:    alu_result = in_a ^ in_b;
            alu_slt:    alu_result = {31'b0, $signed(in_a) < $signed(in_b)};
            alu_pass_b: alu_result = in_b;          // lui
            default:    alu_result = in_a + in_b;
        endcase
    end

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc         <= in_pc;
            out_inst       <= in_inst;
            out_result     <= alu_result;
            out_store_data <= in_store_data;
            out_rd         <= in_rd;
            out_wen        <= in_wen;
            out_mem_op     <= in_mem_op;
        end
    end

    assign ex_busy_rd  = out_rd;                 // held item not yet written
    assign ex_busy_wen = out_valid && out_wen;

endmodule

`default_nettype wire

// File: memory/memory_stage.sv
`default_nettype none
`timescale 1ns/100ps

module memory_stage (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    in_valid,
    input  wire isa_pkg::word_t    in_pc,
    input  wire isa_pkg::word_t    in_inst,
    input  wire isa_pkg::word_t    in_result,
    input  wire isa_pkg::word_t    in_store_data,
    input  wire isa_pkg::reg_idx_t in_rd,
    input  wire                    in_wen,
    input  wire pipe_pkg::mem_op_e in_mem_op,
    input  wire isa_pkg::word_t    rdata,
    output logic                   in_ready,
    output logic                   en,
    output isa_pkg::word_t         addr,
    output logic [3:0]             wmask,
    output isa_pkg::word_t         wdata,
    output logic                   wb_en,
    output isa_pkg::reg_idx_t      wb_rd,
    output isa_pkg::word_t         wb_data,
    output isa_pkg::reg_idx_t      mem_busy_rd,
    output logic                   mem_busy_wen,
    output logic                   retire_valid,
    output isa_pkg::word_t         retire_pc,
    output isa_pkg::word_t         retire_inst,
    output logic                   retire_wen,
    output isa_pkg::reg_idx_t      retire_rd,
    output isa_pkg::word_t         retire_result
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // access register, rdata arrives while the item sits here
    logic     acc_valid;
    logic     acc_load;
    word_t    acc_pc;
    word_t    acc_inst;
    word_t    acc_result;
    reg_idx_t acc_rd;
    logic     acc_wen;
    // writeback register, drives the regfile write port
    logic     wb_valid;
    logic     wb_wen;
    word_t    wb_pc;
    word_t    wb_inst;

    assign in_ready = 1'b1;   // never back-pressures execute
    assign en       = in_valid && (in_mem_op != mem_none);
    assign addr     = in_result;
    assign wdata    = in_store_data;
    assign wmask    = (in_valid && in_mem_op == mem_store) ? 4'hf : 4'h0;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_valid    <= 1'b0;
            wb_valid     <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            acc_valid    <= in_valid;
            wb_valid     <= acc_valid;
            retire_valid <= wb_valid;   // one pulse per item, in order
        end
    end

    always_ff @(posedge clk) begin
        acc_pc     <= in_pc;
        acc_inst   <= in_inst;
        acc_result <= in_result;
        acc_rd     <= in_rd;
        acc_wen    <= in_wen;
        acc_load   <= (in_mem_op == mem_load);
        wb_pc      <= acc_pc;
        wb_inst    <= acc_inst;
        wb_rd      <= acc_rd;
        wb_wen     <= acc_wen;
        wb_data    <= acc_load ? rdata : acc_result;   // load data lands here
        retire_pc     <= wb_pc;
        retire_inst   <= wb_inst;
        retire_wen    <= wb_wen;
        retire_rd     <= wb_rd;
        retire_result <= wb_data;
    end

    assign wb_en        = wb_valid && wb_wen;
    assign mem_busy_rd  = acc_rd;                // writeback item is bypassed instead
    assign mem_busy_wen = acc_valid && acc_wen;

    // word accesses only, and no write strobe without an access
    a_wmask_idle: assert property (@(posedge clk) disable iff (reset)
        en ? (addr[1:0] == 2'b00) : (wmask == 4'h0))
        else $error("misaligned word access or write mask set without an access");

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`default_nettype none
`timescale 1ns/100ps

module cpu_top #(
    parameter isa_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire isa_pkg::word_t    inst,         // instruction at pc
    input  wire                    inst_ready,
    input  wire isa_pkg::word_t    rdata,        // load data, cycle after en
    output isa_pkg::word_t         pc,
    output logic                   pc_valid,
    output isa_pkg::word_t         addr,
    output isa_pkg::word_t         wdata,
    output logic [3:0]             wmask,
    output logic                   en,
    output logic                   retire_valid,
    output isa_pkg::word_t         retire_pc,
    output isa_pkg::word_t         retire_inst,
    output logic                   retire_wen,
    output isa_pkg::reg_idx_t      retire_rd,
    output isa_pkg::word_t         retire_result
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // fetch to decode
    logic     f_valid;
    logic     f_ready;
    word_t    f_pc;
    word_t    f_inst;

    // register file ports
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // decode to execute
    logic     d_valid;
    logic     d_ready;
    word_t    d_pc;
    word_t    d_inst;
    word_t    d_a;
    word_t    d_b;
    word_t    d_store_data;
    reg_idx_t d_rd;
    logic     d_wen;
    alu_op_e  d_alu_op;
    mem_op_e  d_mem_op;

    // execute to memory
    logic     e_valid;
    logic     e_ready;
    word_t    e_pc;
    word_t    e_inst;
    word_t    e_result;
    word_t    e_store_data;
    reg_idx_t e_rd;
    logic     e_wen;
    mem_op_e  e_mem_op;

    // pending writes seen by the hazard check
    reg_idx_t ex_busy_rd;
    logic     ex_busy_wen;
    reg_idx_t mem_busy_rd;
    logic     mem_busy_wen;

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (
        .clk(clk), .reset(reset),
        .inst(inst), .inst_ready(inst_ready),
        .out_ready(f_ready),
        .pc(pc), .pc_valid(pc_valid),
        .out_valid(f_valid), .out_pc(f_pc), .out_inst(f_inst)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset),
        .in_valid(f_valid), .in_pc(f_pc), .in_inst(f_inst),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_busy_rd(ex_busy_rd), .ex_busy_wen(ex_busy_wen),
        .mem_busy_rd(mem_busy_rd), .mem_busy_wen(mem_busy_wen),
        .out_ready(d_ready),
        .in_ready(f_ready), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .out_valid(d_valid), .out_pc(d_pc), .out_inst(d_inst),
        .out_a(d_a), .out_b(d_b), .out_store_data(d_store_data),
        .out_rd(d_rd), .out_wen(d_wen),
        .out_alu_op(d_alu_op), .out_mem_op(d_mem_op)
    );

    regfile u_regfile (
        .clk(clk), .reset(reset),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset),
        .in_valid(d_valid), .in_pc(d_pc), .in_inst(d_inst),
        .in_a(d_a), .in_b(d_b), .in_store_data(d_store_data),
        .in_rd(d_rd), .in_wen(d_wen),
        .in_alu_op(d_alu_op), .in_mem_op(d_mem_op),
        .out_ready(e_ready),
        .in_ready(d_ready),
        .out_valid(e_valid), .out_pc(e_pc), .out_inst(e_inst),
        .out_result(e_result), .out_store_data(e_store_data),
        .out_rd(e_rd), .out_wen(e_wen), .out_mem_op(e_mem_op),
        .ex_busy_rd(ex_busy_rd), .ex_busy_wen(ex_busy_wen)
    );

    memory_stage u_memory (
        .clk(clk), .reset(reset),
        .in_valid(e_valid), .in_pc(e_pc), .in_inst(e_inst),
        .in_result(e_result), .in_store_data(e_store_data),
        .in_rd(e_rd), .in_wen(e_wen), .in_mem_op(e_mem_op),
        .rdata(rdata),
        .in_ready(e_ready),
        .en(en), .addr(addr), .wmask(wmask), .wdata(wdata),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .mem_busy_rd(mem_busy_rd), .mem_busy_wen(mem_busy_wen),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_inst(retire_inst), .retire_wen(retire_wen),
        .retire_rd(retire_rd), .retire_result(retire_result)
    );

endmodule

`default_nettype wire

// File: verif/tb_cpu_top.sv
`default_nettype none
`timescale 1ns/100ps

module tb_cpu_top;
    import isa_pkg::*;

    localparam int    n_inst     = 400;
    localparam int    max_cycles = n_inst * 8 + 100;
    localparam word_t nop        = {12'h000, 5'd0, f3_add, 5'd0, op_imm};   // addi x0, x0, 0

    logic     clk;
    logic     reset;
    word_t    inst;
    logic     inst_ready;
    word_t    rdata;
    word_t    pc;
    logic     pc_valid;
    word_t    addr;
    word_t    wdata;
    logic [3:0] wmask;
    logic     en;
    logic     retire_valid;
    word_t    retire_pc;
    word_t    retire_inst;
    logic     retire_wen;
    reg_idx_t retire_rd;
    word_t    retire_result;

    word_t      lcg_state = 32'ha29b;
    word_t      program_mem [n_inst];
    word_t      dmem [64];           // what the DUT sees
    word_t      ref_mem [64];        // reference model copy
    word_t      ref_regs [32];
    word_t      rdata_next;
    word_t      fetch_pc;            // pc the instruction port should show
    word_t      access_addr_q [$];   // data accesses in issue order
    word_t      access_data_q [$];
    logic [3:0] access_mask_q [$];
    int         retired;
    int         cycles;
    logic       exp_wen;
    logic       exp_mem;
    logic       exp_store;
    word_t      exp_result;
    word_t      exp_addr;
    word_t      exp_data;

    cpu_top #(.reset_pc(32'h0000_0000)) uut (
        .clk(clk), .reset(reset),
        .inst(inst), .inst_ready(inst_ready), .rdata(rdata),
        .pc(pc), .pc_valid(pc_valid),
        .addr(addr), .wdata(wdata), .wmask(wmask), .en(en),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_inst(retire_inst), .retire_wen(retire_wen),
        .retire_rd(retire_rd), .retire_result(retire_result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'h0, lcg_state[31:16]};   // low bits of an lcg are weak
    endfunction

    function automatic word_t fill_word(input int i);
        word_t a;
        a = i * 4;
        return {~a[15:0], a[15:0]} ^ 32'h5a5a_0000;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: instruction %0d %s is %h, expected %h",
                                $time, retired, what, got, exp));
        end
    endtask

    task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: instruction %0d %s is %0d, expected %0d",
                                $time, retired, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: instruction %0d %s is %b, expected %b",
                                $time, retired, what, got, exp));
        end
    endtask

    task automatic build_program();
        funct3_t    alu_f3 [5];
        word_t      kind;
        word_t      rnd;
        word_t      rnd_hi;
        word_t      rnd_lo;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        funct3_t    f3;
        logic [11:0] imm;
        logic [19:0] upper;
        int         i;
        alu_f3 = '{f3_add, f3_slt, f3_xor, f3_or, f3_and};
        for (i = 0; i < n_inst; i++) begin
            kind   = lcg_next() % 8;
            rd     = reg_idx_t'(lcg_next() % 8);   // x0..x7 only, lots of hazards
            rs1    = reg_idx_t'(lcg_next() % 8);
            rs2    = reg_idx_t'(lcg_next() % 8);
            f3     = alu_f3[lcg_next() % 5];
            rnd    = lcg_next();
            imm    = rnd[11:0];
            rnd_hi = lcg_next();
            rnd_lo = lcg_next();
            upper  = {rnd_hi[9:0], rnd_lo[9:0]};   // top bit reaches bit 31
            if (kind < 3) begin
                program_mem[i] = {((f3 == f3_add) && imm[0]) ? funct7_sub : 7'b0,
                                  rs2, rs1, f3, rd, op_reg};
            end else if (kind < 5) begin
                program_mem[i] = {imm, rs1, f3, rd, op_imm};
            end else if (kind == 5) begin
                program_mem[i] = {upper, rd, op_lui};
            end else begin
                rnd = (lcg_next() % 64) * 4;   // x0 base, word offsets inside 64 words
                imm = rnd[11:0];
                if (kind == 6) begin
                    program_mem[i] = {imm, 5'd0, f3_word, rd, op_load};
                end else begin
                    program_mem[i] = {imm[11:5], rs2, 5'd0, f3_word, imm[4:0], op_store};
                end
            end
        end
    endtask

    function automatic word_t alu_ref(input funct3_t f3, input logic sub,
                                      input word_t a, input word_t b);
        case (f3)
            f3_add:  return sub ? a - b : a + b;
            f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3_xor:  return a ^ b;
            f3_or:   return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes one instruction on the model state
    task automatic ref_execute(input word_t ins);
        word_t    a;
        word_t    b;
        word_t    imm_i;
        word_t    imm_s;
        reg_idx_t rd;
        a          = ref_regs[ins[19:15]];
        b          = ref_regs[ins[24:20]];
        imm_i      = {{20{ins[31]}}, ins[31:20]};
        imm_s      = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        rd         = ins[11:7];
        exp_wen    = 1'b1;
        exp_mem    = 1'b0;
        exp_store  = 1'b0;
        exp_result = '0;
        exp_addr   = '0;
        exp_data   = b;
        case (ins[6:0])
            op_reg: exp_result = alu_ref(ins[14:12], ins[31:25] == funct7_sub, a, b);
            op_imm: exp_result = alu_ref(ins[14:12], 1'b0, a, imm_i);
            op_lui: exp_result = {ins[31:12], 12'h000};
            op_load: begin
                exp_mem    = 1'b1;
                exp_addr   = a + imm_i;
                exp_result = ref_mem[exp_addr[7:2]];
            end
            default: begin   // sw
                exp_mem   = 1'b1;
                exp_store = 1'b1;
                exp_wen   = 1'b0;
                exp_addr  = a + imm_s;
                ref_mem[exp_addr[7:2]] = b;
            end
        endcase
        if (exp_wen && rd != 5'd0) begin
            ref_regs[rd] = exp_result;   // x0 stays zero
        end
    endtask

    task automatic check_retire();
        word_t      ins;
        word_t      got_addr;
        word_t      got_data;
        logic [3:0] got_mask;
        ins = program_mem[retired];
        ref_execute(ins);
        check_word(retire_pc, word_t'(retired * 4), "retire_pc");
        check_word(retire_inst, ins, "retire_inst");
        check_bit(retire_wen, exp_wen, "retire_wen");
        check_idx(retire_rd, ins[11:7], "retire_rd");
        if (!exp_store) begin
            check_word(retire_result, exp_result, "retire_result");
        end
        if (exp_mem && access_addr_q.size() == 0) begin
            abort_run("a load or store retired without any data memory access");
        end else if (exp_mem) begin
            got_addr = access_addr_q.pop_front();
            got_data = access_data_q.pop_front();
            got_mask = access_mask_q.pop_front();
            check_word(got_addr, exp_addr, "data address");
            check_bit(got_mask != 4'h0, exp_store, "data write");
            if (exp_store) begin
                check_bit(got_mask == 4'hf, 1'b1, "sw wmask all ones");
                check_word(got_data, exp_data, "store data");
            end
        end
        retired++;
    endtask

    // data memory model and retire checks, outputs settled mid-cycle
    task automatic sample_cycle();
        int b;
        rdata_next = '0;
        check_word(pc, fetch_pc, "fetch pc");
        if (cycles == 0) begin
            check_bit(pc_valid, 1'b0, "pc_valid in the first cycle out of reset");
        end
        if (pc_valid && inst_ready) begin
            fetch_pc = fetch_pc + 32'd4;   // taken on the coming edge
        end
        if (en && (addr[31:8] != 0 || addr[1:0] != 0)) begin
            abort_run("the data access falls outside the 64-word memory model");
        end else if (en) begin
            access_addr_q.push_back(addr);
            access_data_q.push_back(wdata);
            access_mask_q.push_back(wmask);
            for (b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    dmem[addr[7:2]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            if (wmask == 4'h0) begin
                rdata_next = dmem[addr[7:2]];   // answered in the next cycle
            end
        end
        if (retire_valid) begin
            check_retire();
        end
    endtask

    task automatic drive_inputs();
        if (pc < n_inst * 4) begin
            inst_ready = (lcg_next() % 10) < 7;   // about 70 percent
            inst       = program_mem[pc[31:2]];
        end else begin
            inst_ready = 1'b0;   // program exhausted
            inst       = nop;
        end
        rdata = rdata_next;
    endtask

    initial begin
        reset      = 1'b1;
        inst_ready = 1'b0;
        inst       = nop;
        rdata      = '0;
        rdata_next = '0;
        fetch_pc   = 32'h0000_0000;
        retired    = 0;
        cycles     = 0;
        build_program();
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_inputs();
        while (retired < n_inst && cycles <= max_cycles) begin
            @(negedge clk);
            sample_cycle();
            cycles++;
            @(posedge clk);
            #1;
            drive_inputs();
        end
        if (retired != n_inst) begin
            $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                     retired, n_inst, cycles);
            $display("=== FAIL ===");
            $fatal(1);
        end else if (access_addr_q.size() != 0) begin
            abort_run("data memory accesses were issued that no load or store retired");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
common/isa_pkg.sv
common/pipe_pkg.sv
source/fetch_stage.sv
decode/regfile.sv
decode/decode_stage.sv
source/execute_stage.sv
memory/memory_stage.sv
source/cpu_top.sv
verif/tb_cpu_top.sv

// File: Bender.yml
package:
  name: rv32i_pipe

dependencies: {}

sources:
  # packages first, then the stages, then the top level
  - files:
      - common/isa_pkg.sv
      - common/pipe_pkg.sv
      - source/fetch_stage.sv
      - decode/regfile.sv
      - decode/decode_stage.sv
      - source/execute_stage.sv
      - memory/memory_stage.sv
      - source/cpu_top.sv

  # testbench, top module tb_cpu_top
  - target: simulation
    files:
      - verif/tb_cpu_top.sv
